//--- Bender.yml
package:
  name: qsys

sources:
  - include_dirs:
      - logic
    files:
      - logic/qsys_pkg.sv
      - logic/qsys_ifc.sv
      - logic/qsys_classifier.sv
      - logic/qsys_cong_man.sv
      - logic/qsys_queue_mem.sv
      - logic/qsys_scheduler.sv
      - logic/qsys_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - dv/qsys_asserts.sv
      - dv/qsys_tb.sv

//--- dv/qsys_asserts.sv
//////////////////////////////////////////////////////////////////////
// Bound into qsys_top, queue status is taken from the memory read link
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module qsys_asserts (
    input logic       core_clk_ifc,
    input logic       arst_n,
    input logic       out_valid,
    input logic       out_last,
    input logic       deq,
    input logic [1:0] deq_qid,
    input logic [3:0] nonempty
);

    // Failed assertions so far
    int fail_count;

    // A last flag always rides on a delivered word
    last_needs_valid: assert property (
        @(posedge core_clk_ifc) disable iff (!arst_n) out_last |-> out_valid
    ) else begin
        $error("out_last high without out_valid");
        fail_count++;
    end

    // Scheduler must never pop a queue with nothing in it
    deq_needs_data: assert property (
        @(posedge core_clk_ifc) disable iff (!arst_n) deq |-> nonempty[deq_qid]
    ) else begin
        $error("deq on empty queue %0d", deq_qid);
        fail_count++;
    end

    // Output quiet while reset is held
    quiet_in_reset: assert property (
        @(posedge core_clk_ifc) !arst_n |-> !out_valid
    ) else begin
        $error("out_valid high during reset");
        fail_count++;
    end

endmodule

bind qsys_top qsys_asserts asserts_i (
    .core_clk_ifc (core_clk_ifc),
    .arst_n       (arst_n),
    .out_valid    (out_valid),
    .out_last     (out_last),
    .deq          (deq),
    .deq_qid      (deq_qid),
    .nonempty     (mem_rd.nonempty)
);

//--- dv/qsys_tb.sv
//////////////////////////////////////////////////////////////////////
// Each directed test starts from a fresh reset and drains the DUT
// Scoreboard keys on out_meta low bits, so metadata errors show as misses
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "qsys_params.svh"

module qsys_tb;

    localparam int DEPTH    = `QSYS_QUEUE_DEPTH;
    localparam int MAX_LEN  = `QSYS_MAX_PKT_WORDS;
    localparam int N_RAND   = 40;
    localparam int RAND_GAP = 1;
    // Input cycles of all tests, doubled for drain time, plus margin
    localparam int RUN_LIMIT = 2 * ((16 + 2 + 4 + 6) * (MAX_LEN + 1)
                                    + N_RAND * (MAX_LEN + RAND_GAP + 1)) + 400;

    logic                             core_clk_ifc;
    logic                             arst_n;
    logic                             in_valid;
    logic [`QSYS_DATA_W-1:0]          in_data;
    logic                             in_last;
    logic [7:0]                       in_meta;
    logic [1:0]                       egr_pause;
    logic                             out_valid;
    logic [`QSYS_DATA_W-1:0]          out_data;
    logic                             out_last;
    logic [7:0]                       out_meta;
    logic [3:0][`QSYS_DROP_CNT_W-1:0] drop_count;

    // Expected words per queue as {last, meta, data}
    logic [`QSYS_DATA_W+8:0] exp_word [4][512];
    int                      exp_wr [4];
    int                      exp_rd [4];
    // Queue of each packet in the order it completed
    logic [1:0]              pkt_order [$];
    logic                    mid_pkt;
    logic [1:0]              mid_q;
    logic [31:0]             rng_state = 32'd79208;
    int                      cycles;
    int                      checks;
    int                      errors;

    qsys_top dut_i (.*);

    initial begin
        core_clk_ifc = 1'b0;
        forever #2 core_clk_ifc = ~core_clk_ifc;
    end

    always @(posedge core_clk_ifc) begin
        cycles <= cycles + 1;
        if (cycles >= RUN_LIMIT) begin
            $display("Run hit the %0d cycle limit with words still missing", RUN_LIMIT);
            $display("** FAIL **");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic int pending_words();
        int n;
        n = 0;
        for (int q = 0; q < 4; q++) begin
            n += exp_wr[q] - exp_rd[q];
        end
        return n;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] want,
                                   input logic [31:0] got);
        errors++;
        $display("[ERROR] %0t ns %s expected %h got %h", $time, name, want, got);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("%0t ns %s", $time, what);
    endtask

    task automatic check_value(input string name, input logic [31:0] want,
                               input logic [31:0] got);
        checks++;
        assert (got == want) else report_mismatch(name, want, got);
    endtask

    task automatic do_reset();
        @(posedge core_clk_ifc);
        arst_n <= 1'b0;
        repeat (3) @(posedge core_clk_ifc);
        arst_n <= 1'b1;
        mid_pkt = 1'b0;
        pkt_order.delete();
    endtask

    task automatic set_pause(input logic [1:0] pause);
        @(posedge core_clk_ifc);
        egr_pause <= pause;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge core_clk_ifc);
    endtask

    // Wait for every expected word, then a little longer for strays
    task automatic wait_drain();
        while (pending_words() != 0) begin
            @(posedge core_clk_ifc);
        end
        idle_cycles(8);
    endtask

    task automatic send_pkt(input logic port, input logic prio, input int len,
                            input bit admit);
        logic [7:0]  meta;
        logic [1:0]  q;
        logic [31:0] word;
        logic [31:0] noise;
        q     = 2'(2 * int'(prio) + int'(port));
        noise = next_random();
        meta  = {noise[5:0], prio, port};
        for (int i = 0; i < len; i++) begin
            word  = next_random();
            noise = next_random();
            @(posedge core_clk_ifc);
            in_valid <= 1'b1;
            in_data  <= word;
            in_last  <= (i == len - 1);
            // Junk metadata after the first word must be ignored
            in_meta  <= (i == 0) ? meta : noise[7:0];
            if (admit) begin
                exp_word[q][exp_wr[q] % 512] = {i == len - 1, meta, word};
                exp_wr[q]++;
            end
        end
        @(posedge core_clk_ifc);
        in_valid <= 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Output monitor

    task automatic score_word();
        logic [1:0]              q;
        logic [`QSYS_DATA_W+8:0] want;
        q = out_meta[1:0];
        checks++;
        assert (!(mid_pkt && q != mid_q))
            else report_failure("packet interleaved with another queue");
        assert (exp_rd[q] != exp_wr[q])
            else report_failure($sformatf("unexpected word for queue %0d", q));
        if (exp_rd[q] != exp_wr[q]) begin
            want = exp_word[q][exp_rd[q] % 512];
            exp_rd[q]++;
            check_value("out_data", want[`QSYS_DATA_W-1:0], out_data);
            check_value("out_meta", 32'(want[`QSYS_DATA_W+7:`QSYS_DATA_W]), 32'(out_meta));
            check_value("out_last", 32'(want[`QSYS_DATA_W+8]), 32'(out_last));
        end
        if (out_last) begin
            pkt_order.push_back(q);
        end
        mid_pkt = !out_last;
        mid_q   = q;
    endtask

    always @(negedge core_clk_ifc) begin
        if (arst_n === 1'b1 && out_valid === 1'b1) begin
            score_word();
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Tests

    task automatic pass_through();
        do_reset();
        set_pause(2'b00);
        for (int q = 0; q < 4; q++) begin
            for (int len = 1; len <= MAX_LEN; len++) begin
                send_pkt(q[0], q[1], len, 1'b1);
            end
        end
        wait_drain();
        check_value("packet count", 16, pkt_order.size());
    endtask

    task automatic priority_order();
        do_reset();
        set_pause(2'b01);
        send_pkt(1'b0, 1'b0, 3, 1'b1);
        send_pkt(1'b0, 1'b1, 2, 1'b1);
        idle_cycles(4);
        set_pause(2'b00);
        wait_drain();
        checks++;
        assert (pkt_order.size() == 2 && pkt_order[0] == 2'd2 && pkt_order[1] == 2'd0)
            else report_failure("priority 1 packet did not leave before priority 0");
    endtask

    task automatic port_alternation();
        do_reset();
        set_pause(2'b11);
        for (int i = 0; i < 2; i++) begin
            send_pkt(1'b0, 1'b0, 2 + i, 1'b1);
            send_pkt(1'b1, 1'b0, 3 - i, 1'b1);
        end
        idle_cycles(4);
        set_pause(2'b00);
        wait_drain();
        check_value("packet count", 4, pkt_order.size());
        for (int i = 1; i < pkt_order.size(); i++) begin
            checks++;
            assert (pkt_order[i][0] != pkt_order[i - 1][0])
                else report_failure("two packets in a row went to the same port");
        end
    endtask

    task automatic tail_drop();
        int occ;
        int drops;
        bit admit;
        occ   = 0;
        drops = 0;
        do_reset();
        set_pause(2'b10);
        for (int i = 0; i < 6; i++) begin
            // Room for a max length packet is needed to admit
            admit = (DEPTH - occ) >= MAX_LEN;
            if (admit) begin
                occ += MAX_LEN;
            end else begin
                drops++;
            end
            send_pkt(1'b1, 1'b1, MAX_LEN, admit);
        end
        idle_cycles(4);
        for (int q = 0; q < 4; q++) begin
            check_value($sformatf("drop_count[%0d]", q), (q == 3) ? drops : 0, drop_count[q]);
        end
        set_pause(2'b00);
        wait_drain();
        check_value("packet count", 6 - drops, pkt_order.size());
    endtask

    task automatic random_traffic();
        logic [31:0] r;
        do_reset();
        set_pause(2'b00);
        for (int i = 0; i < N_RAND; i++) begin
            r = next_random();
            send_pkt(r[2], r[3], int'(r[1:0]) + 1, 1'b1);
            idle_cycles(RAND_GAP);
        end
        wait_drain();
        check_value("packet count", N_RAND, pkt_order.size());
        for (int q = 0; q < 4; q++) begin
            check_value($sformatf("drop_count[%0d]", q), 0, drop_count[q]);
        end
    endtask

    initial begin
        arst_n    = 1'b1;
        in_valid  = 1'b0;
        in_data   = '0;
        in_last   = 1'b0;
        in_meta   = '0;
        egr_pause = 2'b00;
        mid_pkt   = 1'b0;
        pass_through();
        priority_order();
        port_alternation();
        tail_drop();
        random_traffic();
        checks++;
        assert (dut_i.asserts_i.fail_count == 0)
            else report_failure("bound protocol assertions fired during the run");
        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- logic/qsys_classifier.sv
//////////////////////////////////////////////////////////////////////
// Metadata is only sampled on the first word, later values are ignored
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "qsys_params.svh"

module qsys_classifier (
    input  logic                    core_clk_ifc,
    input  logic                    arst_n,
    input  logic                    in_valid,
    input  logic [`QSYS_DATA_W-1:0] in_data,
    input  logic                    in_last,
    input  qsys_pkg::meta_u         in_meta,
    qsys_stage_ifc.src              out
);

    // High when the next valid word opens a packet
    logic            sop;
    qsys_pkg::meta_u meta_hold;
    qsys_pkg::meta_u cur_meta;

    // Take fresh fields at packet start, else reuse the held copy
    always_comb begin
        cur_meta = meta_hold;
        if (sop) begin
            cur_meta.fields.port  = in_meta.fields.port;
            cur_meta.fields.prio  = in_meta.fields.prio;
            cur_meta.fields.spare = in_meta.fields.spare;
        end
    end

    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            sop       <= 1'b1;
            out.valid <= 1'b0;
        end else begin
            out.valid <= in_valid;
            if (in_valid) begin
                sop <= in_last;
            end
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (in_valid) begin
            meta_hold      <= cur_meta;
            out.word.data  <= in_data;
            out.word.last  <= in_last;
            out.word.first <= sop;
            out.word.meta  <= cur_meta;
        end
    end

endmodule

//--- logic/qsys_cong_man.sv
//////////////////////////////////////////////////////////////////////
// Admit needs room for a max packet, so an admitted packet always fits
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "qsys_params.svh"

module qsys_cong_man (
    input  logic                                core_clk_ifc,
    input  logic                                arst_n,
    qsys_stage_ifc.dst                          in,
    input  logic                                deq,
    input  logic [1:0]                          deq_qid,
    qsys_stage_ifc.src                          out,
    output logic [3:0][`QSYS_DROP_CNT_W-1:0]    drop_count
);

    localparam int OCC_W = $clog2(`QSYS_QUEUE_DEPTH) + 1;

    // Words admitted and not yet dequeued, per queue
    logic [3:0][OCC_W-1:0] occ;
    logic [1:0]            in_qid;
    logic                  admit_now;
    logic                  admit_q;
    logic                  admit_cur;
    logic [3:0]            inc;
    logic [3:0]            dec;

    //////////////////////////////////////////////////////////////////////
    // Admit decision

    assign in_qid    = in.word.meta.qid.num;
    assign admit_now = (`QSYS_QUEUE_DEPTH - int'(occ[in_qid])) >= `QSYS_MAX_PKT_WORDS;
    // Decision made on the first word holds for the rest of the packet
    assign admit_cur = in.word.first ? admit_now : admit_q;

    always_comb begin
        for (int q = 0; q < 4; q++) begin
            inc[q] = in.valid && admit_cur && (in_qid == 2'(q));
            dec[q] = deq && (deq_qid == 2'(q));
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Occupancy and drop counters

    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            occ        <= '0;
            admit_q    <= 1'b0;
            drop_count <= '0;
            out.valid  <= 1'b0;
        end else begin
            out.valid <= in.valid && admit_cur;
            if (in.valid && in.word.first) begin
                admit_q <= admit_now;
                // Saturate rather than wrap
                if (!admit_now && !(&drop_count[in_qid])) begin
                    drop_count[in_qid] <= drop_count[in_qid] + 1'b1;
                end
            end
            for (int q = 0; q < 4; q++) begin
                occ[q] <= occ[q] + inc[q] - dec[q];
            end
        end
    end

    // Dropped words leave the payload register untouched
    always_ff @(posedge core_clk_ifc) begin
        if (in.valid && admit_cur) begin
            out.word <= in.word;
        end
    end

endmodule

//--- logic/qsys_ifc.sv
//////////////////////////////////////////////////////////////////////
// No handshake on either link, a word moves whenever it is flagged
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

// Word stream between pipeline stages
interface qsys_stage_ifc;
    logic                  valid;
    qsys_pkg::stage_word_t word;

    modport src (output valid, output word);
    modport dst (input valid, input word);
endinterface

// Queue memory read port, rd_word lags rd_en by one cycle
interface qsys_rd_ifc;
    logic [3:0]            nonempty;
    logic                  rd_en;
    logic [1:0]            rd_qid;
    qsys_pkg::stage_word_t rd_word;

    modport mem (output nonempty, input rd_en, input rd_qid, output rd_word);
    modport sched (input nonempty, output rd_en, output rd_qid, input rd_word);
endinterface

//--- logic/qsys_params.svh
//////////////////////////////////////////////////////////////////////
// Queue depth must be a power of two and hold at least one max packet
//////////////////////////////////////////////////////////////////////
`ifndef QSYS_PARAMS_SVH
`define QSYS_PARAMS_SVH

// Payload word width in bits
`define QSYS_DATA_W 32

// Words per queue, four queues share one memory
`define QSYS_QUEUE_DEPTH 16

// Longest packet the sender may issue, not checked in hardware
`define QSYS_MAX_PKT_WORDS 4

// Per-queue tail drop counter, saturating
`define QSYS_DROP_CNT_W 8

`endif

//--- logic/qsys_pkg.sv
//////////////////////////////////////////////////////////////////////
// Queue number is prio * 2 + port, so bit 0 of a qid is the port
//////////////////////////////////////////////////////////////////////
`include "qsys_params.svh"

package qsys_pkg;

    // Metadata as seen by the sender
    typedef struct packed {
        logic [5:0] spare;
        logic       prio;
        logic       port;
    } meta_fields_t;

    // Same byte read as a queue number
    typedef struct packed {
        logic [5:0] rsvd;
        logic [1:0] num;
    } meta_qid_t;

    typedef union packed {
        meta_fields_t fields;
        meta_qid_t    qid;
    } meta_u;

    // One word as it moves between stages
    typedef struct packed {
        logic [`QSYS_DATA_W-1:0] data;
        logic                    last;
        logic                    first;
        meta_u                   meta;
    } stage_word_t;

endpackage

//--- logic/qsys_queue_mem.sv
//////////////////////////////////////////////////////////////////////
// No overflow check, the congestion manager keeps every queue in range
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "qsys_params.svh"

module qsys_queue_mem (
    input  logic       core_clk_ifc,
    input  logic       arst_n,
    qsys_stage_ifc.dst wr,
    qsys_rd_ifc.mem    rd
);

    localparam int DEPTH  = `QSYS_QUEUE_DEPTH;
    localparam int PTR_W  = $clog2(DEPTH);
    localparam int ADDR_W = PTR_W + 2;

    // Queue n owns entries n*DEPTH up to (n+1)*DEPTH-1
    qsys_pkg::stage_word_t mem [4*DEPTH];

    // One extra wrap bit tells full from empty
    logic [3:0][PTR_W:0] wr_ptr;
    logic [3:0][PTR_W:0] rd_ptr;
    logic [1:0]          wr_qid;
    logic [ADDR_W-1:0]   wr_addr;
    logic [ADDR_W-1:0]   rd_addr;

    assign wr_qid  = wr.word.meta.qid.num;
    assign wr_addr = {wr_qid, wr_ptr[wr_qid][PTR_W-1:0]};
    assign rd_addr = {rd.rd_qid, rd_ptr[rd.rd_qid][PTR_W-1:0]};

    always_comb begin
        for (int q = 0; q < 4; q++) begin
            rd.nonempty[q] = wr_ptr[q] != rd_ptr[q];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Head and tail pointers

    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr.valid) begin
                wr_ptr[wr_qid] <= wr_ptr[wr_qid] + 1'b1;
            end
            if (rd.rd_en) begin
                rd_ptr[rd.rd_qid] <= rd_ptr[rd.rd_qid] + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Storage

    // Write at tail, registered read from head
    always_ff @(posedge core_clk_ifc) begin
        if (wr.valid) begin
            mem[wr_addr] <= wr.word;
        end
        if (rd.rd_en) begin
            rd.rd_word <= mem[rd_addr];
        end
    end

endmodule

//--- logic/qsys_scheduler.sv
//////////////////////////////////////////////////////////////////////
// Pause is only looked at when a packet is picked, never mid-packet
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "qsys_params.svh"

module qsys_scheduler (
    input  logic                    core_clk_ifc,
    input  logic                    arst_n,
    input  logic [1:0]              egr_pause,
    qsys_rd_ifc.sched               rd,
    output logic                    deq,
    output logic [1:0]              deq_qid,
    output logic                    out_valid,
    output logic [`QSYS_DATA_W-1:0] out_data,
    output logic                    out_last,
    output qsys_pkg::meta_u         out_meta
);

    logic       busy;
    logic [1:0] cur_q;
    logic       last_port;
    // Memory output holds a word read last cycle
    logic       rd_vld;
    logic       pkt_done;
    logic       idle;
    logic [3:0] eligible;
    logic       pick_ok;
    logic       pick_prio;
    logic       pick_port;
    logic [1:0] pick_q;
    logic       read_en;
    logic [1:0] read_qid;

    //////////////////////////////////////////////////////////////////////
    // Queue selection

    always_comb begin
        for (int q = 0; q < 4; q++) begin
            eligible[q] = rd.nonempty[q] && !egr_pause[q % 2];
        end
    end

    // Strict priority, then the port not served last if it can go
    always_comb begin
        pick_ok   = |eligible;
        pick_prio = eligible[2] || eligible[3];
        if (eligible[{pick_prio, ~last_port}]) begin
            pick_port = ~last_port;
        end else begin
            pick_port = last_port;
        end
        pick_q = {pick_prio, pick_port};
    end

    // Last word just came back, so a new pick can start this cycle
    assign pkt_done = rd_vld && rd.rd_word.last;
    assign idle     = !busy || pkt_done;

    // Stall mid-packet while the rest has not arrived yet
    always_comb begin
        read_en  = rd.nonempty[cur_q];
        read_qid = cur_q;
        if (idle) begin
            read_en  = pick_ok;
            read_qid = pick_q;
        end
    end

    assign rd.rd_en  = read_en;
    assign rd.rd_qid = read_qid;
    assign deq       = read_en;
    assign deq_qid   = read_qid;

    //////////////////////////////////////////////////////////////////////
    // State and output register

    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            busy      <= 1'b0;
            cur_q     <= 2'd0;
            last_port <= 1'b0;
            rd_vld    <= 1'b0;
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            rd_vld    <= read_en;
            out_valid <= rd_vld;
            out_last  <= pkt_done;
            if (idle) begin
                busy <= pick_ok;
                if (pick_ok) begin
                    cur_q     <= pick_q;
                    last_port <= pick_port;
                end
            end
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (rd_vld) begin
            out_data <= rd.rd_word.data;
            out_meta <= rd.rd_word.meta;
        end
    end

endmodule

//--- logic/qsys_top.sv
//////////////////////////////////////////////////////////////////////
// Input has no back-pressure, egr_pause is the only flow control
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "qsys_params.svh"

module qsys_top (
    input  logic                                core_clk_ifc,
    input  logic                                arst_n,
    input  logic                                in_valid,
    input  logic [`QSYS_DATA_W-1:0]             in_data,
    input  logic                                in_last,
    input  logic [7:0]                          in_meta,
    input  logic [1:0]                          egr_pause,
    output logic                                out_valid,
    output logic [`QSYS_DATA_W-1:0]             out_data,
    output logic                                out_last,
    output logic [7:0]                          out_meta,
    output logic [3:0][`QSYS_DROP_CNT_W-1:0]    drop_count
);

    // Dequeue feedback, scheduler to congestion manager
    logic       deq;
    logic [1:0] deq_qid;

    qsys_stage_ifc cls_to_cm ();
    qsys_stage_ifc cm_to_mem ();
    qsys_rd_ifc    mem_rd ();

    qsys_classifier classifier_i (
        .core_clk_ifc (core_clk_ifc),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .in_data      (in_data),
        .in_last      (in_last),
        .in_meta      (in_meta),
        .out          (cls_to_cm)
    );

    qsys_cong_man cong_man_i (
        .core_clk_ifc (core_clk_ifc),
        .arst_n       (arst_n),
        .in           (cls_to_cm),
        .deq          (deq),
        .deq_qid      (deq_qid),
        .out          (cm_to_mem),
        .drop_count   (drop_count)
    );

    qsys_queue_mem queue_mem_i (
        .core_clk_ifc (core_clk_ifc),
        .arst_n       (arst_n),
        .wr           (cm_to_mem),
        .rd           (mem_rd)
    );

    qsys_scheduler scheduler_i (
        .core_clk_ifc (core_clk_ifc),
        .arst_n       (arst_n),
        .egr_pause    (egr_pause),
        .rd           (mem_rd),
        .deq          (deq),
        .deq_qid      (deq_qid),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .out_last     (out_last),
        .out_meta     (out_meta)
    );

endmodule

//--- sim.f
+incdir+logic
logic/qsys_pkg.sv
logic/qsys_ifc.sv
logic/qsys_classifier.sv
logic/qsys_cong_man.sv
logic/qsys_queue_mem.sv
logic/qsys_scheduler.sv
logic/qsys_top.sv
dv/qsys_asserts.sv
dv/qsys_tb.sv
